/* Makefile */
# Verilator build and run of the LC-3b subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_lc3b_system
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control (
    input  lc3b_pkg::lc3b_opcode i_opcode,
    input  logic                 i_ir_5,
    output lc3b_pkg::lc3b_aluop  o_aluop,
    output logic                 o_alumux_sel,
    output logic                 o_load_regfile,
    output logic                 o_load_cc,
    output logic                 o_d_read,
    output logic                 o_d_write,
    output logic                 o_is_branch,
    output logic                 o_is_halt
);
    import lc3b_pkg::*;

    always_comb begin
        o_aluop        = alu_pass;
        o_alumux_sel   = 1'b0;
        o_load_regfile = 1'b0;
        o_load_cc      = 1'b0;
        o_d_read       = 1'b0;
        o_d_write      = 1'b0;
        o_is_branch    = 1'b0;
        o_is_halt      = 1'b0;
        case (i_opcode)
            op_add: begin
                o_aluop        = alu_add;
                // bit 5 picks imm5 over sr2
                o_alumux_sel   = i_ir_5;
                o_load_regfile = 1'b1;
                o_load_cc      = 1'b1;
            end
            op_and: begin
                o_aluop        = alu_and;
                o_alumux_sel   = i_ir_5;
                o_load_regfile = 1'b1;
                o_load_cc      = 1'b1;
            end
            op_not: begin
                o_aluop        = alu_not;
                o_load_regfile = 1'b1;
                o_load_cc      = 1'b1;
            end
            op_ldr: begin
                o_d_read       = 1'b1;
                o_load_regfile = 1'b1;
                o_load_cc      = 1'b1;
            end
            op_str: begin
                o_d_write = 1'b1;
            end
            op_br: begin
                o_is_branch = 1'b1;
            end
            // trap only stops the core
            op_trap: begin
                o_is_halt = 1'b1;
            end
            default: begin
                o_aluop = alu_pass;
            end
        endcase
    end

endmodule : cpu_control

/* design/cpu_datapath.sv */
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module cpu_datapath (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_run,
    input  lc3b_pkg::lc3b_aluop     i_aluop,
    input  logic                    i_alumux_sel,
    input  logic                    i_load_regfile,
    input  logic                    i_load_cc,
    input  logic                    i_d_read,
    input  logic                    i_d_write,
    input  logic                    i_is_branch,
    input  logic                    i_is_halt,
    output lc3b_pkg::lc3b_opcode    o_opcode,
    output logic                    o_ir_5,
    output logic                    o_i_mem_read,
    output lc3b_pkg::lc3b_word      o_i_mem_address,
    input  logic                    i_i_mem_resp,
    input  lc3b_pkg::lc3b_word      i_i_mem_rdata,
    output logic                    o_d_mem_read,
    output logic                    o_d_mem_write,
    output lc3b_pkg::lc3b_word      o_d_mem_address,
    output lc3b_pkg::lc3b_word      o_d_mem_wdata,
    output lc3b_pkg::lc3b_mem_wmask o_d_mem_byte_enable,
    input  logic                    i_d_mem_resp,
    input  lc3b_pkg::lc3b_word      i_d_mem_rdata,
    output logic                    o_halted
);
    import lc3b_pkg::*;

    lc3b_dp_state state;
    lc3b_word     pc;
    lc3b_word     fetch_addr;
    lc3b_word     if_pc;
    lc3b_word     if_ir;
    logic         if_valid;
    logic         fetch_pending;
    logic         drop_resp;
    lc3b_word     regfile [8];
    lc3b_nzp      nzp;
    lc3b_reg      mem_dest;

    lc3b_reg      dest;
    lc3b_reg      src1;
    lc3b_reg      src2;
    lc3b_imm5     imm5;
    lc3b_offset6  offset6;
    lc3b_word     src1_data;
    lc3b_word     src2_data;
    lc3b_word     alumux_out;
    lc3b_word     alu_out;
    lc3b_word     mem_addr;
    lc3b_word     br_target;
    lc3b_word     next_fetch;
    logic         exec_fire;
    logic         br_taken;
    logic         fetch_start;
    logic         wb_en;
    logic         cc_en;
    lc3b_reg      wb_dest;
    lc3b_word     wb_data;
    lc3b_nzp      wb_nzp;

    // decode straight out of the if-stage register
    assign o_opcode = lc3b_opcode'(if_ir[15:12]);
    assign o_ir_5   = if_ir[5];
    assign dest     = if_ir[11:9];
    assign src1     = if_ir[8:6];
    // STR takes its store data from the dest field
    assign src2     = i_d_write ? if_ir[11:9] : if_ir[2:0];
    assign imm5     = if_ir[4:0];
    assign offset6  = if_ir[5:0];

    assign src1_data  = regfile[src1];
    assign src2_data  = regfile[src2];
    assign alumux_out = i_alumux_sel ? {{11{imm5[4]}}, imm5} : src2_data;

    always_comb begin
        case (i_aluop)
            alu_add:  alu_out = src1_data + alumux_out;
            alu_and:  alu_out = src1_data & alumux_out;
            alu_not:  alu_out = ~src1_data;
            alu_pass: alu_out = src1_data;
            default:  alu_out = src1_data;
        endcase
    end

    // word offsets, shifted to byte addresses
    assign mem_addr  = src1_data + {{9{offset6[5]}}, offset6, 1'b0};
    assign br_target = if_pc + 16'd2 + {{6{if_ir[8]}}, if_ir[8:0], 1'b0};

    assign exec_fire  = (state == dp_execute) && if_valid;
    assign br_taken   = exec_fire && i_is_branch && |(if_ir[11:9] & nzp);
    assign next_fetch = br_taken ? br_target : pc;

    // the IR is always drained before a fetch started here can answer
    assign fetch_start = (!fetch_pending || i_i_mem_resp) && !(exec_fire && i_is_halt)
                       && ((state == dp_execute) || (state == dp_idle && i_run));

    assign wb_en   = (exec_fire && i_load_regfile && !i_d_read)
                   || (state == dp_mem_wait && i_d_mem_resp && o_d_mem_read);
    assign cc_en   = (exec_fire && i_load_cc && !i_d_read)
                   || (state == dp_mem_wait && i_d_mem_resp && o_d_mem_read);
    assign wb_dest = (state == dp_mem_wait) ? mem_dest : dest;
    assign wb_data = (state == dp_mem_wait) ? i_d_mem_rdata : alu_out;
    assign wb_nzp  = wb_data[15] ? 3'b100 : ((wb_data == '0) ? 3'b010 : 3'b001);

    assign o_i_mem_read        = fetch_pending;
    assign o_i_mem_address     = fetch_addr;
    assign o_d_mem_byte_enable = 2'b11;
    assign o_halted            = (state == dp_halted);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc            <= `LC3B_RESET_PC;
            fetch_pending <= 1'b0;
            drop_resp     <= 1'b0;
            if_valid      <= 1'b0;
        end else begin
            if (fetch_start) begin
                pc            <= next_fetch + 16'd2;
                fetch_pending <= 1'b1;
            end else begin
                if (br_taken) begin
                    pc <= br_target;
                end
                if (i_i_mem_resp) begin
                    fetch_pending <= 1'b0;
                end
            end
            // a taken branch orphans the fetch still in flight
            if (i_i_mem_resp) begin
                drop_resp <= 1'b0;
            end else if (br_taken && fetch_pending) begin
                drop_resp <= 1'b1;
            end
            if (i_i_mem_resp && !drop_resp && !br_taken) begin
                if_valid <= 1'b1;
            end else if (exec_fire) begin
                if_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state         <= dp_idle;
            o_d_mem_read  <= 1'b0;
            o_d_mem_write <= 1'b0;
            nzp           <= 3'b010;
            regfile       <= '{default: '0};
        end else begin
            case (state)
                dp_idle: begin
                    if (i_run) begin
                        state <= dp_execute;
                    end
                end
                dp_execute: begin
                    if (exec_fire && i_is_halt) begin
                        state <= dp_halted;
                    end else if (exec_fire && (i_d_read || i_d_write)) begin
                        state         <= dp_mem_wait;
                        o_d_mem_read  <= i_d_read;
                        o_d_mem_write <= i_d_write;
                    end
                end
                dp_mem_wait: begin
                    if (i_d_mem_resp) begin
                        state         <= dp_execute;
                        o_d_mem_read  <= 1'b0;
                        o_d_mem_write <= 1'b0;
                    end
                end
                default: begin
                    // halted until reset
                    state <= dp_halted;
                end
            endcase
            if (wb_en) begin
                regfile[wb_dest] <= wb_data;
            end
            if (cc_en) begin
                nzp <= wb_nzp;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (fetch_start) begin
            fetch_addr <= next_fetch;
        end
        if (i_i_mem_resp) begin
            if_ir <= i_i_mem_rdata;
            if_pc <= fetch_addr;
        end
        if (exec_fire && (i_d_read || i_d_write)) begin
            o_d_mem_address <= mem_addr;
            o_d_mem_wdata   <= src2_data;
            mem_dest        <= dest;
        end
    end

    // pending requests keep their address until the arbiter answers
    a_i_addr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_i_mem_read && !i_i_mem_resp) |=> $stable(o_i_mem_address));
    a_d_addr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        ((o_d_mem_read || o_d_mem_write) && !i_d_mem_resp) |=> $stable(o_d_mem_address));

endmodule : cpu_datapath

/* design/lc3b_defs.svh */
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// byte address of the first fetch after reset
`define LC3B_RESET_PC 16'h0100

// unified memory depth in 16-bit words
`define LC3B_MEM_WORDS 1024

// cycles from a registered grant to the response pulse
`define LC3B_MEM_LATENCY 2

`endif

/* design/lc3b_pkg.sv */
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;
    typedef logic [4:0]  lc3b_imm5;
    typedef logic [5:0]  lc3b_offset6;
    typedef logic [1:0]  lc3b_mem_wmask;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_aluop;

    // execute stage sequencing
    typedef enum logic [1:0] {dp_idle, dp_execute, dp_mem_wait, dp_halted} lc3b_dp_state;

    typedef enum logic [1:0] {
        arb_free,
        arb_grant_ext,
        arb_grant_data,
        arb_grant_instr
    } lc3b_arb_state;

endpackage

/* design/lc3b_system.sv */
`timescale 1ns/1ps

module lc3b_system (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_run,
    output logic               o_halted,
    input  logic               i_ext_read,
    input  logic               i_ext_write,
    input  lc3b_pkg::lc3b_word i_ext_addr,
    input  lc3b_pkg::lc3b_word i_ext_wdata,
    output lc3b_pkg::lc3b_word o_ext_rdata,
    output logic               o_ext_resp
);
    import lc3b_pkg::*;

    // decoder levels
    lc3b_opcode    opcode;
    logic          ir_5;
    lc3b_aluop     aluop;
    logic          alumux_sel;
    logic          load_regfile;
    logic          load_cc;
    logic          d_read;
    logic          d_write;
    logic          is_branch;
    logic          is_halt;

    // cpu ports
    logic          i_mem_read;
    lc3b_word      i_mem_address;
    logic          i_mem_resp;
    lc3b_word      i_mem_rdata;
    logic          d_mem_read;
    logic          d_mem_write;
    lc3b_word      d_mem_address;
    lc3b_word      d_mem_wdata;
    lc3b_mem_wmask d_mem_byte_enable;
    logic          d_mem_resp;
    lc3b_word      d_mem_rdata;

    // shared memory port
    logic          mem_read;
    logic          mem_write;
    lc3b_word      mem_addr;
    lc3b_word      mem_wdata;
    lc3b_mem_wmask mem_wmask;
    logic          mem_resp;
    lc3b_word      mem_rdata;

    cpu_control u_control (
        .i_opcode(opcode), .i_ir_5(ir_5),
        .o_aluop(aluop), .o_alumux_sel(alumux_sel),
        .o_load_regfile(load_regfile), .o_load_cc(load_cc),
        .o_d_read(d_read), .o_d_write(d_write),
        .o_is_branch(is_branch), .o_is_halt(is_halt)
    );

    cpu_datapath u_datapath (
        .i_clk, .i_arst_n, .i_run,
        .i_aluop(aluop), .i_alumux_sel(alumux_sel),
        .i_load_regfile(load_regfile), .i_load_cc(load_cc),
        .i_d_read(d_read), .i_d_write(d_write),
        .i_is_branch(is_branch), .i_is_halt(is_halt),
        .o_opcode(opcode), .o_ir_5(ir_5),
        .o_i_mem_read(i_mem_read), .o_i_mem_address(i_mem_address),
        .i_i_mem_resp(i_mem_resp), .i_i_mem_rdata(i_mem_rdata),
        .o_d_mem_read(d_mem_read), .o_d_mem_write(d_mem_write),
        .o_d_mem_address(d_mem_address), .o_d_mem_wdata(d_mem_wdata),
        .o_d_mem_byte_enable(d_mem_byte_enable),
        .i_d_mem_resp(d_mem_resp), .i_d_mem_rdata(d_mem_rdata),
        .o_halted
    );

    // instruction port never writes
    mem_arbiter u_arbiter (
        .i_clk, .i_arst_n,
        .i_ext_read, .i_ext_write, .i_ext_addr, .i_ext_wdata,
        .o_ext_resp, .o_ext_rdata,
        .i_data_read(d_mem_read), .i_data_write(d_mem_write),
        .i_data_addr(d_mem_address), .i_data_wdata(d_mem_wdata),
        .i_data_wmask(d_mem_byte_enable),
        .o_data_resp(d_mem_resp), .o_data_rdata(d_mem_rdata),
        .i_instr_read(i_mem_read), .i_instr_write(1'b0),
        .i_instr_addr(i_mem_address), .i_instr_wdata(16'h0000),
        .i_instr_wmask(2'b00),
        .o_instr_resp(i_mem_resp), .o_instr_rdata(i_mem_rdata),
        .o_mem_read(mem_read), .o_mem_write(mem_write),
        .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata), .o_mem_wmask(mem_wmask),
        .i_mem_resp(mem_resp), .i_mem_rdata(mem_rdata)
    );

    unified_memory u_memory (
        .i_clk, .i_arst_n,
        .i_read(mem_read), .i_write(mem_write),
        .i_addr(mem_addr), .i_wdata(mem_wdata), .i_wmask(mem_wmask),
        .o_rdata(mem_rdata), .o_resp(mem_resp)
    );

endmodule : lc3b_system

/* design/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_ext_read,
    input  logic                    i_ext_write,
    input  lc3b_pkg::lc3b_word      i_ext_addr,
    input  lc3b_pkg::lc3b_word      i_ext_wdata,
    output logic                    o_ext_resp,
    output lc3b_pkg::lc3b_word      o_ext_rdata,
    input  logic                    i_data_read,
    input  logic                    i_data_write,
    input  lc3b_pkg::lc3b_word      i_data_addr,
    input  lc3b_pkg::lc3b_word      i_data_wdata,
    input  lc3b_pkg::lc3b_mem_wmask i_data_wmask,
    output logic                    o_data_resp,
    output lc3b_pkg::lc3b_word      o_data_rdata,
    input  logic                    i_instr_read,
    input  logic                    i_instr_write,
    input  lc3b_pkg::lc3b_word      i_instr_addr,
    input  lc3b_pkg::lc3b_word      i_instr_wdata,
    input  lc3b_pkg::lc3b_mem_wmask i_instr_wmask,
    output logic                    o_instr_resp,
    output lc3b_pkg::lc3b_word      o_instr_rdata,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output lc3b_pkg::lc3b_word      o_mem_addr,
    output lc3b_pkg::lc3b_word      o_mem_wdata,
    output lc3b_pkg::lc3b_mem_wmask o_mem_wmask,
    input  logic                    i_mem_resp,
    input  lc3b_pkg::lc3b_word      i_mem_rdata
);
    import lc3b_pkg::*;

    lc3b_arb_state state;

    // fixed priority of external over data over instruction
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= arb_free;
        end else begin
            case (state)
                arb_free: begin
                    if (i_ext_read || i_ext_write) begin
                        state <= arb_grant_ext;
                    end else if (i_data_read || i_data_write) begin
                        state <= arb_grant_data;
                    end else if (i_instr_read || i_instr_write) begin
                        state <= arb_grant_instr;
                    end
                end
                default: begin
                    if (i_mem_resp) begin
                        state <= arb_free;
                    end
                end
            endcase
        end
    end

    always_comb begin
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_mem_addr  = '0;
        o_mem_wdata = '0;
        o_mem_wmask = '0;
        case (state)
            arb_grant_ext: begin
                o_mem_read  = i_ext_read;
                o_mem_write = i_ext_write;
                o_mem_addr  = i_ext_addr;
                o_mem_wdata = i_ext_wdata;
                // external writes are always full words
                o_mem_wmask = 2'b11;
            end
            arb_grant_data: begin
                o_mem_read  = i_data_read;
                o_mem_write = i_data_write;
                o_mem_addr  = i_data_addr;
                o_mem_wdata = i_data_wdata;
                o_mem_wmask = i_data_wmask;
            end
            arb_grant_instr: begin
                o_mem_read  = i_instr_read;
                o_mem_write = i_instr_write;
                o_mem_addr  = i_instr_addr;
                o_mem_wdata = i_instr_wdata;
                o_mem_wmask = i_instr_wmask;
            end
            default: begin
                o_mem_read = 1'b0;
            end
        endcase
    end

    assign o_ext_resp    = (state == arb_grant_ext) && i_mem_resp;
    assign o_data_resp   = (state == arb_grant_data) && i_mem_resp;
    assign o_instr_resp  = (state == arb_grant_instr) && i_mem_resp;
    assign o_ext_rdata   = (state == arb_grant_ext) ? i_mem_rdata : '0;
    assign o_data_rdata  = (state == arb_grant_data) ? i_mem_rdata : '0;
    assign o_instr_rdata = (state == arb_grant_instr) ? i_mem_rdata : '0;

    // every memory response lands on exactly one requester
    a_one_resp: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_mem_resp |-> $onehot({o_ext_resp, o_data_resp, o_instr_resp}));

endmodule : mem_arbiter

/* design/unified_memory.sv */
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module unified_memory (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_read,
    input  logic                    i_write,
    input  lc3b_pkg::lc3b_word      i_addr,
    input  lc3b_pkg::lc3b_word      i_wdata,
    input  lc3b_pkg::lc3b_mem_wmask i_wmask,
    output lc3b_pkg::lc3b_word      o_rdata,
    output logic                    o_resp
);
    import lc3b_pkg::*;

    lc3b_word   mem [`LC3B_MEM_WORDS];
    logic [3:0] lat_cnt;

    // answer on the last cycle of the latency window
    assign o_resp  = (i_read || i_write) && (lat_cnt == 4'(`LC3B_MEM_LATENCY - 1));
    assign o_rdata = mem[i_addr[10:1]];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            lat_cnt <= '0;
        end else if (o_resp) begin
            lat_cnt <= '0;
        end else if (i_read || i_write) begin
            lat_cnt <= lat_cnt + 4'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_resp && i_write) begin
            if (i_wmask[0]) begin
                mem[i_addr[10:1]][7:0] <= i_wdata[7:0];
            end
            if (i_wmask[1]) begin
                mem[i_addr[10:1]][15:8] <= i_wdata[15:8];
            end
        end
    end

    a_req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        ((i_read || i_write) && !o_resp) |=> (i_read || i_write));

endmodule : unified_memory

/* dv/tb_lc3b_system.sv */
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module tb_lc3b_system;
    import lc3b_pkg::*;

    localparam int BODY_LEN    = 24;
    localparam int WAIT_LIMIT  = 200;
    localparam int HALT_LIMIT  = 20000;
    localparam int MODEL_LIMIT = 2000;

    logic     i_clk;
    logic     i_arst_n;
    logic     i_run;
    logic     o_halted;
    logic     i_ext_read;
    logic     i_ext_write;
    lc3b_word i_ext_addr;
    lc3b_word i_ext_wdata;
    lc3b_word o_ext_rdata;
    logic     o_ext_resp;

    int       errors;
    int       timeouts;
    int       ext_wait;
    lc3b_word model_mem [`LC3B_MEM_WORDS];
    lc3b_word model_reg [8];
    lc3b_nzp  model_cc;
    lc3b_word prog [$];

    lc3b_system uut (
        .i_clk, .i_arst_n, .i_run, .o_halted,
        .i_ext_read, .i_ext_write, .i_ext_addr, .i_ext_wdata,
        .o_ext_rdata, .o_ext_resp
    );

    always #10 i_clk = ~i_clk;

    task automatic apply_reset();
        i_arst_n = 1'b0;
        i_run    = 1'b0;
        repeat (16) @(negedge i_clk);
        i_arst_n = 1'b1;
        @(negedge i_clk);
    endtask

    // one external access that returns on a falling edge with the request dropped
    task automatic ext_access(input logic is_write, input lc3b_word addr,
                              input lc3b_word wdata, output lc3b_word rdata);
        int   cycles;
        logic done;
        cycles      = 0;
        done        = 1'b0;
        rdata       = '0;
        i_ext_read  = !is_write;
        i_ext_write = is_write;
        i_ext_addr  = addr;
        i_ext_wdata = wdata;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge i_clk);
            if (o_ext_resp) begin
                rdata = o_ext_rdata;
                done  = 1'b1;
            end
            cycles++;
        end
        ext_wait = cycles;
        // request stays up through the edge that ends the resp cycle
        @(negedge i_clk);
        i_ext_read  = 1'b0;
        i_ext_write = 1'b0;
        if (!done) begin
            timeouts++;
            $display("timeout: external access to %h got no response", addr);
        end
    endtask

    task automatic load_word(input lc3b_word addr, input lc3b_word data);
        lc3b_word ignored;
        ext_access(1'b1, addr, data, ignored);
        model_mem[addr[10:1]] = data;
    endtask

    task automatic check_idle();
        repeat (20) begin
            @(negedge i_clk);
            if (o_halted !== 1'b0 || o_ext_resp !== 1'b0) begin
                errors++;
                $display("[ERROR] idle: expected halted=0 resp=0, actual halted=%b resp=%b",
                         o_halted, o_ext_resp);
            end
        end
    endtask

    task automatic ext_round_trip();
        logic     written [40];
        lc3b_word addr;
        lc3b_word data;
        int       slot;
        for (int i = 0; i < 40; i++) begin
            written[i] = 1'b0;
        end
        // few slots and many writes so some get overwritten
        for (int n = 0; n < 48 && timeouts == 0; n++) begin
            slot = $urandom_range(0, 39);
            addr = 16'(1200 + 2 * slot);
            load_word(addr, 16'($urandom));
            written[slot] = 1'b1;
        end
        for (int s = 0; s < 40 && timeouts == 0; s++) begin
            if (written[s]) begin
                addr = 16'(1200 + 2 * s);
                ext_access(1'b0, addr, 16'h0000, data);
                if (timeouts == 0 && data !== model_mem[addr[10:1]]) begin
                    errors++;
                    $display("[ERROR] ext_round_trip @%h: expected %h, actual %h",
                             addr, model_mem[addr[10:1]], data);
                end
                // cpu is idle so the grant comes on the first edge
                if (timeouts == 0 && ext_wait != `LC3B_MEM_LATENCY) begin
                    errors++;
                    $display("[ERROR] ext_round_trip latency @%h: expected %0d, actual %0d",
                             addr, `LC3B_MEM_LATENCY, ext_wait);
                end
            end
        end
    endtask

    // any register but the R6 base
    function automatic lc3b_reg pick_dest();
        lc3b_reg r;
        r = 3'($urandom_range(0, 6));
        if (r == 3'd6) begin
            r = 3'd7;
        end
        return r;
    endfunction

    function automatic lc3b_word enc_alu(input lc3b_reg dr, input lc3b_reg sr1);
        int       kind;
        lc3b_word w;
        kind = $urandom_range(0, 2);
        if (kind == 2) begin
            w = {4'b1001, dr, sr1, 6'b111111};
        end else begin
            w = {(kind == 0) ? 4'b0001 : 4'b0101, dr, sr1, 6'b000000};
            if ($urandom_range(0, 1) == 1) begin
                w[5:0] = {1'b1, 5'($urandom)};
            end else begin
                w[5:0] = {3'b000, 3'($urandom)};
            end
        end
        return w;
    endfunction

    task automatic gen_program(input logic use_mem, input logic use_branch);
        int      roll;
        int      reach;
        lc3b_reg r;
        prog.delete();
        // every register gets a known value and R6 stays zero
        for (int k = 0; k < 8; k++) begin
            r = 3'(k);
            prog.push_back({4'b0101, r, r, 6'b100000});
            if (k != 6) begin
                prog.push_back({4'b0001, r, r, 1'b1, 5'($urandom)});
            end
        end
        for (int i = 0; i < BODY_LEN; i++) begin
            roll = $urandom_range(0, 9);
            if (use_branch && roll < 3) begin
                // forward only and at most to the start of the dump
                reach = BODY_LEN - 1 - i;
                if (reach > 3) begin
                    reach = 3;
                end
                prog.push_back({4'b0000, 3'($urandom), 9'($urandom_range(0, reach))});
            end else if (use_mem && roll >= 6) begin
                if ($urandom_range(0, 1) == 1) begin
                    prog.push_back({4'b0110, pick_dest(), 3'd6, 6'($urandom_range(0, 31))});
                end else begin
                    // word 31 holds the dump pointer
                    prog.push_back({4'b0111, 3'($urandom), 3'd6, 6'($urandom_range(0, 30))});
                end
            end else begin
                prog.push_back(enc_alu(pick_dest(), 3'($urandom)));
            end
        end
        // dump R0..R7 to words 40..47 through the pointer in word 31
        prog.push_back({4'b0101, 3'd6, 3'd6, 6'b100000});
        prog.push_back({4'b0110, 3'd6, 3'd6, 6'd31});
        for (int k = 0; k < 8; k++) begin
            prog.push_back({4'b0111, 3'(k), 3'd6, 6'(8 + k)});
        end
        prog.push_back(16'hF025);
    endtask

    // instruction-set interpreter over the model memory image
    task automatic model_run(input string name);
        lc3b_word pc;
        lc3b_word ir;
        lc3b_word opb;
        lc3b_word ea;
        lc3b_word res;
        logic     halted;
        logic     wr;
        int       steps;
        pc       = `LC3B_RESET_PC;
        halted   = 1'b0;
        steps    = 0;
        res      = '0;
        model_cc = 3'b000;
        while (!halted && steps < MODEL_LIMIT) begin
            ir  = model_mem[pc[10:1]];
            pc  = pc + 16'd2;
            wr  = 1'b0;
            opb = ir[5] ? {{11{ir[4]}}, ir[4:0]} : model_reg[ir[2:0]];
            ea  = model_reg[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
            case (ir[15:12])
                4'b0001: begin
                    res = model_reg[ir[8:6]] + opb;
                    wr  = 1'b1;
                end
                4'b0101: begin
                    res = model_reg[ir[8:6]] & opb;
                    wr  = 1'b1;
                end
                4'b1001: begin
                    res = ~model_reg[ir[8:6]];
                    wr  = 1'b1;
                end
                4'b0110: begin
                    res = model_mem[ea[10:1]];
                    wr  = 1'b1;
                end
                4'b0111: begin
                    model_mem[ea[10:1]] = model_reg[ir[11:9]];
                end
                4'b0000: begin
                    if (|(ir[11:9] & model_cc)) begin
                        pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
                    end
                end
                4'b1111: begin
                    halted = 1'b1;
                end
                default: begin
                end
            endcase
            if (wr) begin
                model_reg[ir[11:9]] = res;
                model_cc = res[15] ? 3'b100 : ((res == 16'h0000) ? 3'b010 : 3'b001);
            end
            steps++;
        end
        if (!halted) begin
            errors++;
            $display("model for %s never reached TRAP", name);
        end
    endtask

    task automatic run_program(input string name, input logic use_mem,
                               input logic use_branch, input logic contend);
        lc3b_word rd;
        int       cycles;
        int       k;
        gen_program(use_mem, use_branch);
        apply_reset();
        for (int w = 0; w < 31 && timeouts == 0; w++) begin
            load_word(16'(2 * w), 16'($urandom));
        end
        load_word(16'd62, 16'h0040);
        for (int p = 0; p < prog.size() && timeouts == 0; p++) begin
            load_word(16'(`LC3B_RESET_PC + 2 * p), prog[p]);
        end
        if (timeouts != 0) begin
            return;
        end
        model_run(name);
        i_run  = 1'b1;
        cycles = 0;
        while (!o_halted && cycles < HALT_LIMIT && timeouts == 0) begin
            if (contend && $urandom_range(0, 3) == 0) begin
                k = $urandom_range(0, prog.size() - 1);
                ext_access(1'b0, 16'(`LC3B_RESET_PC + 2 * k), 16'h0000, rd);
                if (timeouts == 0 && rd !== prog[k]) begin
                    errors++;
                    $display("[ERROR] %s program word %0d: expected %h, actual %h",
                             name, k, prog[k], rd);
                end
            end else begin
                @(negedge i_clk);
            end
            cycles++;
        end
        i_run = 1'b0;
        if (!o_halted) begin
            if (timeouts == 0) begin
                timeouts++;
                $display("timeout: program %s did not halt", name);
            end
            return;
        end
        for (int r = 0; r < 8 && timeouts == 0; r++) begin
            ext_access(1'b0, 16'(80 + 2 * r), 16'h0000, rd);
            if (timeouts == 0 && rd !== model_reg[r]) begin
                errors++;
                $display("[ERROR] %s R%0d: expected %h, actual %h", name, r, model_reg[r], rd);
            end
        end
        for (int w = 0; w < 32 && timeouts == 0; w++) begin
            ext_access(1'b0, 16'(2 * w), 16'h0000, rd);
            if (timeouts == 0 && rd !== model_mem[w]) begin
                errors++;
                $display("[ERROR] %s data word %0d: expected %h, actual %h",
                         name, w, model_mem[w], rd);
            end
        end
        // halt holds until the next reset
        if (o_halted !== 1'b1) begin
            errors++;
            $display("[ERROR] %s halted after dump: expected 1, actual %b", name, o_halted);
        end
    endtask

    initial begin
        void'($urandom(32'h0a0b9f68));
        errors      = 0;
        timeouts    = 0;
        ext_wait    = 0;
        i_clk       = 1'b0;
        i_arst_n    = 1'b0;
        i_run       = 1'b0;
        i_ext_read  = 1'b0;
        i_ext_write = 1'b0;
        i_ext_addr  = '0;
        i_ext_wdata = '0;
        apply_reset();
        check_idle();
        ext_round_trip();
        for (int n = 0; n < 4 && timeouts == 0; n++) begin
            run_program("alu", 1'b0, 1'b0, 1'b0);
        end
        for (int n = 0; n < 4 && timeouts == 0; n++) begin
            run_program("ldst", 1'b1, 1'b0, 1'b0);
        end
        for (int n = 0; n < 6 && timeouts == 0; n++) begin
            run_program("branch", 1'b0, 1'b1, 1'b0);
        end
        // external reads compete with a running program
        for (int n = 0; n < 4 && timeouts == 0; n++) begin
            run_program("contention", 1'b1, 1'b1, 1'b1);
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_lc3b_system

/* vlog.f */
+incdir+design
design/lc3b_pkg.sv
design/cpu_control.sv
design/cpu_datapath.sv
design/mem_arbiter.sv
design/unified_memory.sv
design/lc3b_system.sv
dv/tb_lc3b_system.sv
